// File: project.f
src/ahb_pkg.sv
src/apb_pkg.sv
src/ahb_slave_fsm.sv
src/apb_master_fsm.sv
src/apb_byte_lanes.sv
src/ahb_apb_bridge.sv
testbench/tb_ahb_apb_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bridge testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_ahb_apb_bridge

verilator --binary --timing --timescale 1ns/100ps --top-module "$TOP" -f project.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
  exit 0
else
  exit 1
fi

// File: testbench/tb_ahb_apb_bridge.sv
// Self-checking testbench for the AHB to APB bridge with an APB memory model
`default_nettype none
`timescale 1ns/100ps

module tb_ahb_apb_bridge;
  import ahb_pkg::*;
  import apb_pkg::*;

  localparam int     CLK_PERIOD      = 100;
  localparam int     DRIVE_DELAY     = 10;
  localparam int     NROWS           = 15;
  localparam int     WATCHDOG_CYCLES = NROWS * 40 + 100;
  localparam paddr_t ERR_BASE        = 10'h3F0;

  // One AHB transfer with its expected outcome
  typedef struct packed {
    htrans_t trans;
    logic    write;
    hsize_t  size;
    haddr_t  addr;
    hprot_t  prot;
    hdata_t  wdata;
    hdata_t  exp_rdata;
    logic    exp_resp;
  } row_t;

  logic    HCLK;
  logic    HRESETn;
  logic    HSEL;
  haddr_t  HADDR;
  hdata_t  HWDATA;
  logic    HWRITE;
  hsize_t  HSIZE;
  hprot_t  HPROT;
  htrans_t HTRANS;
  logic    HREADY;
  hdata_t  HRDATA;
  logic    HREADYOUT;
  logic    HRESP;
  pdata_t  PRDATA;
  logic    PREADY;
  logic    PSLVERR;
  logic    PSEL;
  logic    PENABLE;
  pprot_t  PPROT;
  logic    PWRITE;
  logic    PSTRB;
  paddr_t  PADDR;
  pdata_t  PWDATA;

  // Table, APB memory and run state
  row_t        rows [NROWS];
  string       row_name [NROWS];
  pdata_t      mem [1024];
  logic [31:0] rnd_state;
  string       cur_name;
  row_t        cur_row;
  int          beat_cnt;
  int          setup_cnt;
  int          err_data  = 0;
  int          err_resp  = 0;
  int          err_apb   = 0;
  int          err_other = 0;

  ahb_apb_bridge i_dut (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWDATA    (HWDATA),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HPROT     (HPROT),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .PRDATA    (PRDATA),
    .PREADY    (PREADY),
    .PSLVERR   (PSLVERR),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PPROT     (PPROT),
    .PWRITE    (PWRITE),
    .PSTRB     (PSTRB),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Initial memory contents built from every address bit
  function automatic pdata_t fill_byte(input paddr_t a);
    return a[7:0] ^ {4{a[9:8]}};
  endfunction

  // Privileged from HPROT[1] and instruction when HPROT[0] is low
  function automatic pprot_t exp_pprot(input hprot_t prot);
    return {~prot[0], 1'b0, prot[1]};
  endfunction

  function automatic pdata_t lane_byte(input hdata_t wdata, input haddr_t addr, input int k);
    int ln;
    ln = (int'(addr[1:0]) + k) % 4;
    return pdata_t'(wdata >> (8 * ln));
  endfunction

  // Beats due for a row up to the first erroring address
  function automatic int exp_beats(input row_t r);
    int     n;
    int     cnt;
    paddr_t pa;
    cnt = 0;
    if ((r.trans == HTRANS_IDLE) || (r.trans == HTRANS_BUSY))
      return 0;
    case (r.size)
      HSIZE_WORD:  n = 4;
      HSIZE_HWORD: n = 2;
      default:     n = 1;
    endcase
    for (int k = 0; k < n; k++)
    begin
      cnt++;
      pa = r.addr[9:0] + paddr_t'(k);
      if (pa >= ERR_BASE)
        break;
    end
    return cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_hdata(input string name, input hdata_t exp, input hdata_t act);
    if (act !== exp)
    begin
      err_data++;
      $display("Fail %s HRDATA expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_hresp(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_resp++;
      $display("Fail %s HRESP expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_paddr(input string name, input paddr_t exp, input paddr_t act);
    if (act !== exp)
    begin
      err_apb++;
      $display("Fail %s PADDR expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pprot(input string name, input pprot_t exp, input pprot_t act);
    if (act !== exp)
    begin
      err_apb++;
      $display("Fail %s PPROT expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_pdata(input string name, input pdata_t exp, input pdata_t act);
    if (act !== exp)
    begin
      err_apb++;
      $display("Fail %s PWDATA expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string sig, input logic exp,
                            input logic act);
    if (act !== exp)
    begin
      err_apb++;
      $display("Fail %s %s expected %b actual %b", name, sig, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////
  task automatic set_row(input int i, input string name, input htrans_t trans,
                         input logic write, input hsize_t size, input haddr_t addr,
                         input hprot_t prot, input hdata_t wdata, input hdata_t exp_rdata,
                         input logic exp_resp);
    row_name[i] = name;
    rows[i]     = '{trans, write, size, addr, prot, wdata, exp_rdata, exp_resp};
  endtask

  task automatic load_table();
    // Upper HADDR bits never reach PADDR
    set_row(0, "wr_word", HTRANS_NONSEQ, 1'b1, HSIZE_WORD, 32'h4000_0100, 4'b0011,
            32'hA1B2_C3D4, 32'h0000_0000, HRESP_OKAY);
    set_row(1, "rd_word", HTRANS_NONSEQ, 1'b0, HSIZE_WORD, 32'h0000_0100, 4'b0011,
            32'h0000_0000, 32'hA1B2_C3D4, HRESP_OKAY);
    set_row(2, "rd_half_o2", HTRANS_NONSEQ, 1'b0, HSIZE_HWORD, 32'h0000_0102, 4'b0010,
            32'h0000_0000, 32'hA1B2_0000, HRESP_OKAY);
    set_row(3, "rd_byte_o1", HTRANS_SEQ, 1'b0, HSIZE_BYTE, 32'h0000_0101, 4'b0001,
            32'h0000_0000, 32'h0000_C300, HRESP_OKAY);
    set_row(4, "wr_byte_o3", HTRANS_NONSEQ, 1'b1, HSIZE_BYTE, 32'h8000_0103, 4'b0000,
            32'h5E00_0000, 32'h0000_0000, HRESP_OKAY);
    set_row(5, "rd_word_mix", HTRANS_NONSEQ, 1'b0, HSIZE_WORD, 32'h0000_0100, 4'b0000,
            32'h0000_0000, 32'h5EB2_C3D4, HRESP_OKAY);
    set_row(6, "idle", HTRANS_IDLE, 1'b1, HSIZE_WORD, 32'h0000_0200, 4'b0011,
            32'hFFFF_FFFF, 32'h0000_0000, HRESP_OKAY);
    set_row(7, "wr_half_o0", HTRANS_NONSEQ, 1'b1, HSIZE_HWORD, 32'h0000_0200, 4'b0010,
            32'h0000_BEEF, 32'h0000_0000, HRESP_OKAY);
    set_row(8, "busy", HTRANS_BUSY, 1'b1, HSIZE_HWORD, 32'h0000_0202, 4'b0001,
            32'hDEAD_0000, 32'h0000_0000, HRESP_OKAY);
    set_row(9, "wr_half_o2", HTRANS_SEQ, 1'b1, HSIZE_HWORD, 32'h0000_0202, 4'b0001,
            32'h1234_0000, 32'h0000_0000, HRESP_OKAY);
    set_row(10, "rd_word_200", HTRANS_NONSEQ, 1'b0, HSIZE_WORD, 32'h0000_0200, 4'b0011,
            32'h0000_0000, 32'h1234_BEEF, HRESP_OKAY);
    // Error window at the top of the APB map
    set_row(11, "err_rd_word", HTRANS_NONSEQ, 1'b0, HSIZE_WORD, 32'h0000_03F0, 4'b0010,
            32'h0000_0000, 32'h0000_0000, HRESP_ERROR);
    set_row(12, "err_wr_byte", HTRANS_NONSEQ, 1'b1, HSIZE_BYTE, 32'h0000_03FF, 4'b0001,
            32'hAB00_0000, 32'h0000_0000, HRESP_ERROR);
    set_row(13, "rd_after_err", HTRANS_NONSEQ, 1'b0, HSIZE_WORD, 32'h0000_0100, 4'b0001,
            32'h0000_0000, 32'h5EB2_C3D4, HRESP_OKAY);
    set_row(14, "rd_byte_o0", HTRANS_NONSEQ, 1'b0, HSIZE_BYTE, 32'h0000_0200, 4'b0000,
            32'h0000_0000, 32'h0000_00EF, HRESP_OKAY);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AHB master side with one table row per call
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_row(input int i);
    int err_low;
    int wait_cycles;
    int beats_exp;
    int err_exp;
    cur_name    = row_name[i];
    cur_row     = rows[i];
    beat_cnt    = 0;
    setup_cnt   = 0;
    err_low     = 0;
    wait_cycles = 0;
    beats_exp   = exp_beats(rows[i]);
    err_exp     = (rows[i].exp_resp == HRESP_ERROR) ? 1 : 0;
    // Address phase
    HSEL   = 1'b1;
    HTRANS = rows[i].trans;
    HWRITE = rows[i].write;
    HSIZE  = rows[i].size;
    HADDR  = rows[i].addr;
    HPROT  = rows[i].prot;
    @(posedge HCLK);
    #DRIVE_DELAY;
    // Data phase
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    HWDATA = rows[i].wdata;
    do
    begin
      @(negedge HCLK);
      wait_cycles++;
      if (!HREADYOUT && (HRESP == HRESP_ERROR))
        err_low++;
    end
    while (!HREADYOUT);
    check_hresp(cur_name, rows[i].exp_resp, HRESP);
    if (!rows[i].write && (rows[i].exp_resp == HRESP_OKAY) && (beats_exp > 0))
      check_hdata(cur_name, rows[i].exp_rdata, HRDATA);
    if (err_low != err_exp)
    begin
      err_other++;
      $display("%s: HREADYOUT was low for %0d ERROR cycles, expected %0d",
               cur_name, err_low, err_exp);
    end
    if ((beats_exp == 0) && (wait_cycles != 1))
    begin
      err_other++;
      $display("%s: HREADYOUT dropped for a transfer that moves no data", cur_name);
    end
    if (beat_cnt != beats_exp)
    begin
      err_other++;
      $display("%s: saw %0d APB beats where %0d were due", cur_name, beat_cnt, beats_exp);
    end
    if (setup_cnt != beat_cnt)
    begin
      err_other++;
      $display("%s: saw %0d APB setup cycles for %0d beats", cur_name, setup_cnt, beat_cnt);
    end
    @(posedge HCLK);
    #DRIVE_DELAY;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB slave model and beat monitor
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    rnd_state = 32'hc28f5219;
    forever
    begin
      @(posedge HCLK);
      #DRIVE_DELAY;
      rnd_state = next_random(rnd_state);
      // About one wait state in four
      PREADY  = (rnd_state[1:0] != 2'b00);
      PRDATA  = mem[PADDR];
      PSLVERR = PSEL && (PADDR >= ERR_BASE);
    end
  end

  // Sampled mid-cycle where APB outputs are stable
  always @(negedge HCLK)
  begin
    if (HRESETn && PSEL && !PENABLE)
    begin
      setup_cnt++;
      check_paddr(cur_name, cur_row.addr[9:0] + paddr_t'(beat_cnt), PADDR);
      check_pprot(cur_name, exp_pprot(cur_row.prot), PPROT);
      check_flag(cur_name, "PWRITE", cur_row.write, PWRITE);
      check_flag(cur_name, "PSTRB", cur_row.write, PSTRB);
      if (cur_row.write)
        check_pdata(cur_name, lane_byte(cur_row.wdata, cur_row.addr, beat_cnt), PWDATA);
    end
    // Beat completes on the next edge
    if (HRESETn && PSEL && PENABLE && PREADY)
    begin
      if (PWRITE && !PSLVERR)
        mem[PADDR] = PWDATA;
      beat_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Clock, sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  initial
  begin
    HRESETn   = 1'b0;
    HSEL      = 1'b0;
    HADDR     = '0;
    HWDATA    = '0;
    HWRITE    = 1'b0;
    HSIZE     = HSIZE_BYTE;
    HPROT     = '0;
    HTRANS    = HTRANS_IDLE;
    // Single slave so the bus is ready outside its own transfers
    HREADY    = 1'b1;
    PRDATA    = '0;
    PREADY    = 1'b0;
    PSLVERR   = 1'b0;
    cur_name  = "reset";
    cur_row   = '0;
    beat_cnt  = 0;
    setup_cnt = 0;
    for (int a = 0; a < 1024; a++)
      mem[a] = fill_byte(paddr_t'(a));
    load_table();
    repeat (16) @(posedge HCLK);
    #DRIVE_DELAY;
    HRESETn = 1'b1;
    @(posedge HCLK);
    #DRIVE_DELAY;
    for (int i = 0; i < NROWS; i++)
      run_row(i);
    $display("Error counts: data %0d, response %0d, apb %0d, other %0d",
             err_data, err_resp, err_apb, err_other);
    if ((err_data + err_resp + err_apb + err_other) == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge HCLK);
    $display("Run timed out after %0d cycles while on row %s", WATCHDOG_CYCLES, cur_name);
    $display("Error counts: data %0d, response %0d, apb %0d, other %0d",
             err_data, err_resp, err_apb, err_other);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/ahb_apb_bridge.sv
// AHB to APB bridge top: joins the AHB slave FSM, APB master FSM and byte lanes
`default_nettype none
`timescale 1ns/100ps

module ahb_apb_bridge (
  input  wire                   HCLK,
  input  wire                   HRESETn,
  // AHB slave side
  input  wire                   HSEL,
  input  wire ahb_pkg::haddr_t  HADDR,
  input  wire ahb_pkg::hdata_t  HWDATA,
  input  wire                   HWRITE,
  input  wire ahb_pkg::hsize_t  HSIZE,
  input  wire ahb_pkg::hprot_t  HPROT,
  input  wire ahb_pkg::htrans_t HTRANS,
  input  wire                   HREADY,
  output ahb_pkg::hdata_t       HRDATA,
  output logic                  HREADYOUT,
  output logic                  HRESP,
  // APB master side
  input  wire apb_pkg::pdata_t  PRDATA,
  input  wire                   PREADY,
  input  wire                   PSLVERR,
  output logic                  PSEL,
  output logic                  PENABLE,
  output apb_pkg::pprot_t       PPROT,
  output logic                  PWRITE,
  output logic                  PSTRB,
  output apb_pkg::paddr_t       PADDR,
  output apb_pkg::pdata_t       PWDATA
);
  import ahb_pkg::*;
  import apb_pkg::*;

  // Strobes between the two FSMs
  logic        xfer_start;
  logic        xfer_done;
  ahb_xfer_t   xfer;
  apb_result_t result;

  // Byte lane hookup
  beat_t       lane;
  logic        rd_clear;
  logic        rd_capture;
  pdata_t      lane_wdata;
  hdata_t      rd_word;

  ahb_slave_fsm i_ahb_slave (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HSEL       (HSEL),
    .HADDR      (HADDR),
    .HWDATA     (HWDATA),
    .HWRITE     (HWRITE),
    .HSIZE      (HSIZE),
    .HPROT      (HPROT),
    .HTRANS     (HTRANS),
    .HREADY     (HREADY),
    .xfer_done  (xfer_done),
    .result     (result),
    .HRDATA     (HRDATA),
    .HREADYOUT  (HREADYOUT),
    .HRESP      (HRESP),
    .xfer_start (xfer_start),
    .xfer       (xfer)
  );

  apb_master_fsm i_apb_master (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .xfer_start (xfer_start),
    .xfer       (xfer),
    .lane_wdata (lane_wdata),
    .rd_word    (rd_word),
    .PREADY     (PREADY),
    .PSLVERR    (PSLVERR),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PPROT      (PPROT),
    .PWRITE     (PWRITE),
    .PSTRB      (PSTRB),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA),
    .lane       (lane),
    .rd_clear   (rd_clear),
    .rd_capture (rd_capture),
    .xfer_done  (xfer_done),
    .result     (result)
  );

  apb_byte_lanes i_byte_lanes (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .xfer       (xfer),
    .lane       (lane),
    .PRDATA     (PRDATA),
    .rd_clear   (rd_clear),
    .rd_capture (rd_capture),
    .lane_wdata (lane_wdata),
    .rd_word    (rd_word)
  );

endmodule

`default_nettype wire

// File: src/apb_byte_lanes.sv
// Byte lanes: picks the write byte for the current beat and assembles read data
`default_nettype none
`timescale 1ns/100ps

module apb_byte_lanes (
  input  wire                     HCLK,
  input  wire                     HRESETn,
  input  wire ahb_pkg::ahb_xfer_t xfer,
  input  wire apb_pkg::beat_t     lane,
  input  wire apb_pkg::pdata_t    PRDATA,
  input  wire                     rd_clear,
  input  wire                     rd_capture,
  output apb_pkg::pdata_t         lane_wdata,
  output ahb_pkg::hdata_t         rd_word
);
  import apb_pkg::*;

  // Bit offset of current lane in the word
  logic [4:0] lane_ofs;

  assign lane_ofs = {lane, 3'b000};

  // Write byte for this beat
  assign lane_wdata = xfer.wdata[lane_ofs +: PDATA_W];

  ////////////////////////////////////////////////////////////////////////////
  // Read accumulator
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      rd_word <= '0;
    // Unread lanes stay zero
    else if (rd_clear)
      rd_word <= '0;
    else if (rd_capture)
      rd_word[lane_ofs +: PDATA_W] <= PRDATA;
  end

endmodule

`default_nettype wire

// File: src/apb_master_fsm.sv
// APB master FSM: runs setup and access phases per byte beat and reports the outcome
`default_nettype none
`timescale 1ns/100ps

module apb_master_fsm (
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire                       xfer_start,
  input  wire ahb_pkg::ahb_xfer_t   xfer,
  input  wire apb_pkg::pdata_t      lane_wdata,
  input  wire ahb_pkg::hdata_t      rd_word,
  input  wire                       PREADY,
  input  wire                       PSLVERR,
  output logic                      PSEL,
  output logic                      PENABLE,
  output apb_pkg::pprot_t           PPROT,
  output logic                      PWRITE,
  output logic                      PSTRB,
  output apb_pkg::paddr_t           PADDR,
  output apb_pkg::pdata_t           PWDATA,
  output apb_pkg::beat_t            lane,
  output logic                      rd_clear,
  output logic                      rd_capture,
  output logic                      xfer_done,
  output apb_pkg::apb_result_t      result
);
  import ahb_pkg::*;
  import apb_pkg::*;

  apb_state_t state;
  beat_t      beat;
  beat_t      last_beat;
  pprot_t     prot_map;
  logic       slverr;
  logic       start;
  logic       beat_end;

  // Index of last beat for a size
  function automatic beat_t beats_last(input hsize_t size);
    case (size)
      HSIZE_WORD:  beats_last = 2'd3;
      HSIZE_HWORD: beats_last = 2'd1;
      HSIZE_BYTE:  beats_last = 2'd0;
      // Wider sizes unsupported, treat as byte
      default:     beats_last = 2'd0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    prot_map                  = '0;
    prot_map[PPROT_PRIV_BIT]  = xfer.prot[HPROT_PRIV_BIT];
    // Opcode fetch when HPROT says not data
    prot_map[PPROT_INSTR_BIT] = ~xfer.prot[HPROT_DATA_BIT];
  end

  assign start     = (state == APB_IDLE) && xfer_start;
  assign beat_end  = (state == APB_ACCESS) && PREADY;
  assign last_beat = beats_last(xfer.size);

  // Lane wraps within the word
  assign lane       = xfer.addr[1:0] + beat;
  assign PWDATA     = lane_wdata;
  assign rd_clear   = start;
  assign rd_capture = beat_end;

  // Read word already holds the last byte when done pulses
  assign result.rdata  = rd_word;
  assign result.slverr = slverr;

  ////////////////////////////////////////////////////////////////////////////
  // Setup / access sequencing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state     <= APB_IDLE;
      PSEL      <= 1'b0;
      PENABLE   <= 1'b0;
      PPROT     <= '0;
      PWRITE    <= 1'b0;
      PSTRB     <= 1'b0;
      PADDR     <= '0;
      beat      <= '0;
      slverr    <= 1'b0;
      xfer_done <= 1'b0;
    end
    else
    begin
      xfer_done <= 1'b0;
      case (state)
        APB_IDLE:
        begin
          if (start)
          begin
            state   <= APB_SETUP;
            PSEL    <= 1'b1;
            PENABLE <= 1'b0;
            PPROT   <= prot_map;
            PWRITE  <= xfer.write;
            // Full byte strobe on writes only
            PSTRB   <= xfer.write;
            PADDR   <= xfer.addr[PADDR_W-1:0];
            beat    <= '0;
            slverr  <= 1'b0;
          end
        end
        APB_SETUP:
        begin
          PENABLE <= 1'b1;
          state   <= APB_ACCESS;
        end
        APB_ACCESS:
        begin
          // PREADY low stretches this phase
          if (PREADY)
          begin
            PENABLE <= 1'b0;
            slverr  <= PSLVERR;
            if (PSLVERR || (beat == last_beat))
            begin
              PSEL      <= 1'b0;
              xfer_done <= 1'b1;
              state     <= APB_IDLE;
            end
            else
            begin
              // Next byte
              beat  <= beat + 1'b1;
              PADDR <= PADDR + 1'b1;
              state <= APB_SETUP;
            end
          end
        end
        default: state <= APB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/ahb_slave_fsm.sv
// AHB slave FSM: accepts single transfers, captures write data, returns the response
`default_nettype none
`timescale 1ns/100ps

module ahb_slave_fsm (
  input  wire                       HCLK,
  input  wire                       HRESETn,
  input  wire                       HSEL,
  input  wire ahb_pkg::haddr_t      HADDR,
  input  wire ahb_pkg::hdata_t      HWDATA,
  input  wire                       HWRITE,
  input  wire ahb_pkg::hsize_t      HSIZE,
  input  wire ahb_pkg::hprot_t      HPROT,
  input  wire ahb_pkg::htrans_t     HTRANS,
  input  wire                       HREADY,
  input  wire                       xfer_done,
  input  wire apb_pkg::apb_result_t result,
  output ahb_pkg::hdata_t           HRDATA,
  output logic                      HREADYOUT,
  output logic                      HRESP,
  output logic                      xfer_start,
  output ahb_pkg::ahb_xfer_t        xfer
);
  import ahb_pkg::*;

  ahb_state_t state;
  logic       xfer_req;

  // Address phase decode
  always_comb
  begin
    case (HTRANS)
      HTRANS_NONSEQ,
      HTRANS_SEQ:  xfer_req = HSEL & HREADY;
      // No data moves, plain OKAY
      HTRANS_IDLE,
      HTRANS_BUSY: xfer_req = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state      <= AHB_IDLE;
      HREADYOUT  <= 1'b1;
      HRESP      <= HRESP_OKAY;
      xfer_start <= 1'b0;
    end
    else
    begin
      // Single-cycle strobe
      xfer_start <= 1'b0;
      case (state)
        AHB_IDLE:
        begin
          HRESP <= HRESP_OKAY;
          if (xfer_req)
          begin
            // Hold off master until APB side is done
            HREADYOUT <= 1'b0;
            state     <= AHB_CAPTURE;
          end
        end
        AHB_CAPTURE:
        begin
          // HWDATA valid now, kick off APB side
          xfer_start <= 1'b1;
          state      <= AHB_WAIT;
        end
        AHB_WAIT:
        begin
          if (xfer_done)
          begin
            if (result.slverr)
            begin
              // First cycle of two-cycle ERROR
              HRESP <= HRESP_ERROR;
              state <= AHB_ERROR;
            end
            else
            begin
              HREADYOUT <= 1'b1;
              state     <= AHB_IDLE;
            end
          end
        end
        AHB_ERROR:
        begin
          // Second ERROR cycle, HRESP held
          HREADYOUT <= 1'b1;
          state     <= AHB_IDLE;
        end
        default: state <= AHB_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transfer capture and read data
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK)
  begin
    if ((state == AHB_IDLE) && xfer_req)
    begin
      xfer.addr  <= HADDR;
      xfer.write <= HWRITE;
      xfer.size  <= HSIZE;
      xfer.prot  <= HPROT;
    end
    // Data phase follows one cycle later
    if (state == AHB_CAPTURE)
      xfer.wdata <= HWDATA;
    if ((state == AHB_WAIT) && xfer_done)
      HRDATA <= result.rdata;
  end

endmodule

`default_nettype wire

// File: src/apb_pkg.sv
// APB package: APB-side widths, protection bits, beat type and master result
`default_nettype none

package apb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // APB widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int PADDR_W = 10;
  localparam int PDATA_W = 8;

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [PDATA_W-1:0] pdata_t;
  typedef logic [2:0]         pprot_t;

  // PPROT bit positions; bit 1 stays secure
  localparam int PPROT_PRIV_BIT  = 0;
  localparam int PPROT_INSTR_BIT = 2;

  // Beat index, at most four beats per word
  typedef logic [1:0] beat_t;

  ////////////////////////////////////////////////////////////////////////////
  // Result and master states
  ////////////////////////////////////////////////////////////////////////////
  // Outcome back to the AHB side, 33 bits
  typedef struct packed {
    ahb_pkg::hdata_t rdata;
    logic            slverr;
  } apb_result_t;

  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_t;

endpackage

`default_nettype wire

// File: src/ahb_pkg.sv
// AHB package: bus encodings, AHB-side widths and the captured transfer record
`default_nettype none

package ahb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // AHB widths
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [2:0]  hsize_t;
  typedef logic [1:0]  htrans_t;
  typedef logic [3:0]  hprot_t;

  // Transfer sizes, word and below only
  localparam hsize_t HSIZE_BYTE  = 3'b000;
  localparam hsize_t HSIZE_HWORD = 3'b001;
  localparam hsize_t HSIZE_WORD  = 3'b010;

  // Transfer types
  localparam htrans_t HTRANS_IDLE   = 2'b00;
  localparam htrans_t HTRANS_BUSY   = 2'b01;
  localparam htrans_t HTRANS_NONSEQ = 2'b10;
  localparam htrans_t HTRANS_SEQ    = 2'b11;

  // HPROT bit positions
  localparam int HPROT_DATA_BIT = 0;
  localparam int HPROT_PRIV_BIT = 1;

  // Response codes
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer record and slave states
  ////////////////////////////////////////////////////////////////////////////
  // Address phase plus write data, 72 bits
  typedef struct packed {
    haddr_t addr;
    logic   write;
    hsize_t size;
    hprot_t prot;
    hdata_t wdata;
  } ahb_xfer_t;

  typedef enum logic [1:0] {
    AHB_IDLE    = 2'b00,
    AHB_CAPTURE = 2'b01,
    AHB_WAIT    = 2'b10,
    AHB_ERROR   = 2'b11
  } ahb_state_t;

endpackage

`default_nettype wire
